// ==== src.f ====
common/rvCorePkg.sv
common/rvIsaPkg.sv
src/fetchUnit.sv
decode/hazardUnit.sv
decode/instrDecoder.sv
decode/regFile.sv
execute/executeStage.sv
src/memWbStage.sv
src/rvCore.sv
+incdir+verif
verif/rvCoreTb.sv

// ==== verif/rvRefModel.svh ====
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

////////////////////////////////////////
// Encoders and program builder
////////////////////////////////////////
localparam word_t haltInstr = 32'h0000_006F;  // JAL x0,0 spins in place

word_t prog [0:1023];
word_t refMem [0:1023];
int    progLen;
word_t storeOff;   // Next store slot above x31
word_t expAddr [$];
word_t expData [$];

function automatic word_t encR(logic [6:0] f7, regAddr_t r2, regAddr_t r1, logic [2:0] f3,
                               regAddr_t rd);
  return {f7, r2, r1, f3, rd, R_OP};
endfunction

function automatic word_t encI(word_t imm, regAddr_t r1, logic [2:0] f3, regAddr_t rd,
                               opcode_t op);
  return {imm[11:0], r1, f3, rd, op};
endfunction

function automatic word_t encB(word_t imm, logic [2:0] f3, regAddr_t r1, regAddr_t r2);
  return {imm[12], imm[10:5], r2, r1, f3, imm[4:1], imm[11], BRANCH};
endfunction

function automatic word_t encJ(word_t imm, regAddr_t rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
endfunction

task automatic emit(word_t w);
  prog[progLen] = w;
  progLen++;
endtask

task automatic storeReg(regAddr_t r);
  emit({storeOff[11:5], r, 5'd31, 3'b010, storeOff[4:0], STORE});  // SW r, off(x31)
  storeOff += 4;
endtask

// LUI plus ADDI, upper part rounded for the signed low half
task automatic loadConst(regAddr_t rd, word_t v);
  word_t hi;
  hi = (v + 32'h800) >> 12;
  emit({hi[19:0], rd, LUI});
  emit(encI(v, rd, 3'b000, rd, I_OP));
endtask

////////////////////////////////////////
// Instruction-level model
////////////////////////////////////////
function automatic word_t aluRef(logic [2:0] f3, logic alt, word_t a, word_t b);
  case (f3)
    3'd0:    return alt ? a - b : a + b;
    3'd1:    return a << b[4:0];
    3'd2:    return word_t'($signed(a) < $signed(b));
    3'd3:    return word_t'(a < b);
    3'd4:    return a ^ b;
    3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6:    return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic branchTaken(logic [2:0] f3, word_t a, word_t b);
  case (f3)
    3'b000:  return a == b;
    3'b001:  return a != b;
    3'b100:  return $signed(a) < $signed(b);
    3'b101:  return $signed(a) >= $signed(b);
    3'b110:  return a < b;
    default: return a >= b;
  endcase
endfunction

// Runs the program to the halt word, records every store
function automatic void runReference();
  word_t    regs [32];
  word_t    pc;
  word_t    next;
  word_t    instr;
  word_t    a;
  word_t    b;
  word_t    iImm;
  word_t    addr;
  word_t    res;
  logic     wr;
  regAddr_t rd;
  regs = '{default: '0};
  pc   = resetPc;
  for (int step = 0; step < 4096; step++) begin
    instr = prog[pc[11:2]];
    if (instr == haltInstr) break;
    a    = regs[instr[19:15]];
    b    = regs[instr[24:20]];
    rd   = instr[11:7];
    iImm = {{20{instr[31]}}, instr[31:20]};
    next = pc + 4;
    wr   = 1'b1;
    res  = '0;
    case (instr[6:0])
      LUI:    res = {instr[31:12], 12'b0};
      AUIPC:  res = pc + {instr[31:12], 12'b0};
      JAL: begin
        res  = next;
        next = pc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      JALR: begin
        res  = next;
        next = (a + iImm) & ~32'd1;
      end
      BRANCH: begin
        wr = 1'b0;
        if (branchTaken(instr[14:12], a, b))
          next = pc + {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      LOAD: begin
        addr = a + iImm;
        res  = refMem[addr[11:2]];
      end
      STORE: begin
        wr   = 1'b0;
        addr = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
        refMem[addr[11:2]] = b;
        expAddr.push_back(addr);
        expData.push_back(b);
      end
      I_OP:    res = aluRef(instr[14:12], instr[30] && instr[14:12] == 3'd5, a, iImm);
      R_OP:    res = aluRef(instr[14:12], instr[30], a, b);
      default: wr = 1'b0;  // Nothing else is legal here
    endcase
    if (wr && rd != '0) regs[rd] = res;
    pc = next;
  end
endfunction

`endif

// ==== verif/rvCoreTb.sv ====
module rvCoreTb import rvCorePkg::*, rvIsaPkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  logic  Clock;
  logic  rst;
  word_t imemAddr;
  word_t imemData;
  word_t dmemAddr;
  word_t dmemWrData;
  logic  dmemWrEn;
  logic  dmemRdEn;
  word_t dmemRdData;
  word_t dmem [0:1023];
  word_t fetchAddr;   // Captured mid-cycle
  word_t dAddr;
  word_t dData;
  logic  dWr;
  logic  dRd;

  `include "rvRefModel.svh"

  rvCore rvCore_i (.*);

  initial begin
    Clock = 1'b0;
    forever #4 Clock = ~Clock;
  end

  task automatic abortRun(string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic checkStoreAddr(word_t got, word_t exp);
    if (got !== exp) abortRun($sformatf("MISMATCH dmemAddr got %h expected %h", got, exp));
  endtask

  task automatic checkStoreData(word_t got, word_t exp);
    if (got !== exp) abortRun($sformatf("MISMATCH dmemWrData got %h expected %h", got, exp));
  endtask

  // Fill depends on every address bit
  function automatic word_t fillWord(int idx);
    return (idx * 32'h9E37_79B9) ^ 32'hC0DE_0000;
  endfunction

  logic [2:0] branchF3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

  task automatic buildProgram();
    word_t x1v;
    word_t x2v;
    word_t imm;
    progLen  = 0;
    storeOff = '0;
    x1v = $urandom();
    x2v = $urandom();
    emit(encI(32'h400, 5'd0, 3'b000, 5'd31, I_OP));  // Store base
    loadConst(5'd1, x1v);
    loadConst(5'd2, x2v);
    // Every R and I operation with its result stored straight away
    for (int f3 = 0; f3 < 8; f3++) begin
      emit(encR(7'b0, 5'd2, 5'd1, 3'(f3), 5'd3));
      storeReg(5'd3);
      imm = (f3 == 1 || f3 == 5) ? word_t'($urandom() & 31) : $urandom();
      emit(encI(imm, 5'd1, 3'(f3), 5'd3, I_OP));
      storeReg(5'd3);
    end
    emit(encR(7'b0100000, 5'd2, 5'd1, 3'd0, 5'd3));  // SUB
    storeReg(5'd3);
    emit(encR(7'b0100000, 5'd2, 5'd1, 3'd5, 5'd3));  // SRA
    storeReg(5'd3);
    emit(encI(32'h400 | ($urandom() & 31), 5'd1, 3'd5, 5'd3, I_OP));  // SRAI
    storeReg(5'd3);
    ////////////////////////////////////////
    // Dependency chains at distance 1 to 3
    emit(encR(7'b0, 5'd2, 5'd1, 3'd0, 5'd4));
    emit(encR(7'b0, 5'd1, 5'd4, 3'd4, 5'd5));
    emit(encR(7'b0100000, 5'd5, 5'd4, 3'd0, 5'd6));
    emit(encR(7'b0, 5'd6, 5'd4, 3'd6, 5'd7));
    emit(nopInstr);
    emit(encR(7'b0, 5'd7, 5'd5, 3'd7, 5'd20));
    storeReg(5'd20);
    storeReg(5'd7);
    storeReg(5'd6);
    // Load-use from a stored word and from fill
    emit(encI(32'h0, 5'd31, 3'b010, 5'd8, LOAD));
    emit(encR(7'b0, 5'd1, 5'd8, 3'd0, 5'd9));
    storeReg(5'd9);
    emit(encI(32'h7F0, 5'd31, 3'b010, 5'd10, LOAD));
    emit(encR(7'b0, 5'd2, 5'd10, 3'd0, 5'd11));
    storeReg(5'd11);
    ////////////////////////////////////////
    // Three operand pairs per branch show both outcomes
    foreach (branchF3[k]) begin
      for (int p = 0; p < 3; p++) begin
        emit(encB(32'd12, branchF3[k], (p == 1) ? 5'd2 : 5'd1, (p == 0) ? 5'd2 : 5'd1));
        storeReg(5'd1);  // Two shadow slots that must not store
        storeReg(5'd2);
        emit(encI(word_t'(16 + 3 * k + p), 5'd0, 3'd0, 5'd12, I_OP));
        storeReg(5'd12);
      end
    end
    // JAL over two slots
    emit(encJ(32'd12, 5'd13));
    storeReg(5'd1);
    storeReg(5'd2);
    storeReg(5'd13);
    // JALR relative to an AUIPC base
    emit({20'h0, 5'd17, AUIPC});
    emit(encI(32'd16, 5'd17, 3'd0, 5'd18, JALR));
    storeReg(5'd1);
    storeReg(5'd2);
    storeReg(5'd18);
    emit({20'($urandom()), 5'd15, AUIPC});
    storeReg(5'd15);
    emit({20'($urandom()), 5'd16, LUI});
    storeReg(5'd16);
    emit(haltInstr);
  endtask

  // Both memories answer one cycle after the address
  always begin
    @(negedge Clock);
    fetchAddr = imemAddr;
    dAddr     = dmemAddr;
    dData     = dmemWrData;
    dWr       = dmemWrEn && !rst;
    dRd       = dmemRdEn && !rst;
    @(posedge Clock);
    #1;
    imemData = prog[fetchAddr[11:2]];
    if (dWr) dmem[dAddr[11:2]] = dData;
    if (dRd) dmemRdData = dmem[dAddr[11:2]];
  end

  // Compare each store in order with the model
  always @(negedge Clock) begin
    if (!rst && dmemWrEn) begin
      if (expAddr.size() == 0) abortRun("store seen after the last expected one");
      checkStoreAddr(dmemAddr, expAddr.pop_front());
      checkStoreData(dmemWrData, expData.pop_front());
      if (expAddr.size() == 0) begin
        $display("all tests passed");
        $finish;
      end
    end
  end

  initial begin
    rst        = 1'b1;
    imemData   = nopInstr;
    dmemRdData = '0;
    void'($urandom(21248));
    foreach (prog[i]) prog[i] = haltInstr;
    foreach (dmem[i]) begin
      dmem[i]   = fillWord(i);
      refMem[i] = fillWord(i);
    end
    buildProgram();
    runReference();
    repeat (3) @(posedge Clock);
    #1 rst = 1'b0;
  end

  // Watchdog scaled to the program
  initial begin
    #2;
    repeat (4 * progLen + 20) @(posedge Clock);
    abortRun("timeout: the core did not make all expected stores in time");
  end

endmodule

// ==== src/rvCore.sv ====
module rvCore import rvCorePkg::*, rvIsaPkg::*; (
  input  logic  Clock,
  input  logic  rst,
  output word_t imemAddr,    // Q100 PC
  input  word_t imemData,    // Valid in Q101
  output word_t dmemAddr,
  output word_t dmemWrData,
  output logic  dmemWrEn,
  output logic  dmemRdEn,
  input  word_t dmemRdData   // Valid in Q104
);
  // Fetch and hazard
  logic      pcEn;
  logic      redirect;
  word_t     redirectPc;
  word_t     pcQ101;
  word_t     pcPlus4Q101;
  word_t     instrQ101;
  // Decode
  regAddr_t  rs1;
  regAddr_t  rs2;
  regAddr_t  rd;
  aluOp_t    aluOp;
  branchOp_t branchOp;
  word_t     imm;
  logic      selAluPc;
  logic      selAluImm;
  logic      isLui;
  logic      isBranch;
  logic      isJump;
  logic      isLoad;
  logic      isStore;
  logic      regWrEn;
  word_t     rdData1;
  word_t     rdData2;
  // Execute to memory
  word_t     aluOut;
  word_t     storeData;
  regAddr_t  rdQ102;
  logic      loadQ102;
  logic      storeQ102;
  logic      regWrEnQ102;
  logic      linkQ102;
  word_t     pcPlus4Q102;
  // Q103 and Q104 write ports
  word_t     aluOutQ103;
  logic      fwdWrEn;
  regAddr_t  fwdAddr;
  logic      wbWrEn;
  regAddr_t  wbAddr;
  word_t     wbData;

  fetchUnit    fetchUnit_i    (.*);
  hazardUnit   hazardUnit_i   (.*, .flush(redirect));  // Squash on taken branch or jump
  instrDecoder instrDecoder_i (.*);
  regFile      regFile_i      (.*, .wrEn(wbWrEn), .wrAddr(wbAddr), .wrData(wbData));
  executeStage executeStage_i (.*);
  memWbStage   memWbStage_i   (.*);

endmodule

// ==== src/memWbStage.sv ====
module memWbStage import rvCorePkg::*; (
  input  logic     Clock,
  input  logic     rst,
  input  word_t    aluOut,
  input  word_t    storeData,
  input  regAddr_t rdQ102,
  input  logic     loadQ102,
  input  logic     storeQ102,
  input  logic     regWrEnQ102,
  input  logic     linkQ102,
  input  word_t    pcPlus4Q102,
  output word_t    dmemAddr,
  output word_t    dmemWrData,
  output logic     dmemWrEn,
  output logic     dmemRdEn,
  input  word_t    dmemRdData,   // Q104
  output word_t    aluOutQ103,
  output logic     fwdWrEn,      // Q103 write port
  output regAddr_t fwdAddr,
  output logic     wbWrEn,       // Q104 write port
  output regAddr_t wbAddr,
  output word_t    wbData
);
  word_t pcPlus4Q103;
  word_t aluOutQ104;
  word_t pcPlus4Q104;
  logic  linkQ103;
  logic  loadQ104;
  logic  linkQ104;

  ////////////////////////////////////////
  // Q103 and Q104 control
  ////////////////////////////////////////
  always_ff @(posedge Clock) begin
    if (rst) begin
      dmemWrEn <= 1'b0;
      dmemRdEn <= 1'b0;
      fwdWrEn  <= 1'b0;
      linkQ103 <= 1'b0;
      loadQ104 <= 1'b0;
      wbWrEn   <= 1'b0;
      linkQ104 <= 1'b0;
    end else begin
      dmemWrEn <= storeQ102;
      dmemRdEn <= loadQ102;
      fwdWrEn  <= regWrEnQ102;
      linkQ103 <= linkQ102;
      loadQ104 <= dmemRdEn;
      wbWrEn   <= fwdWrEn;
      linkQ104 <= linkQ103;
    end
  end

  always_ff @(posedge Clock) begin
    aluOutQ103  <= aluOut;
    dmemWrData  <= storeData;  // Word store, no lane shift
    fwdAddr     <= rdQ102;
    pcPlus4Q103 <= pcPlus4Q102;
    aluOutQ104  <= aluOutQ103;
    wbAddr      <= fwdAddr;
    pcPlus4Q104 <= pcPlus4Q103;
  end

  assign dmemAddr = aluOutQ103;

  // Link beats load beats ALU
  assign wbData = linkQ104 ? pcPlus4Q104 :
                  loadQ104 ? dmemRdData  :
                             aluOutQ104;

endmodule

// ==== execute/executeStage.sv ====
module executeStage import rvCorePkg::*, rvIsaPkg::*; (
  input  logic      Clock,
  input  logic      rst,
  // Decode outputs, Q101
  input  regAddr_t  rs1,
  input  regAddr_t  rs2,
  input  regAddr_t  rd,
  input  aluOp_t    aluOp,
  input  branchOp_t branchOp,
  input  word_t     imm,
  input  logic      selAluPc,
  input  logic      selAluImm,
  input  logic      isLui,
  input  logic      isBranch,
  input  logic      isJump,
  input  logic      isLoad,
  input  logic      isStore,
  input  logic      regWrEn,
  input  word_t     pcQ101,
  input  word_t     pcPlus4Q101,
  input  word_t     rdData1,
  input  word_t     rdData2,
  // Forwarding sources
  input  word_t     aluOutQ103,
  input  logic      fwdWrEn,
  input  regAddr_t  fwdAddr,
  input  logic      wbWrEn,
  input  regAddr_t  wbAddr,
  input  word_t     wbData,
  output logic      redirect,
  output word_t     redirectPc,
  output word_t     aluOut,
  output word_t     storeData,
  output regAddr_t  rdQ102,
  output logic      loadQ102,
  output logic      storeQ102,
  output logic      regWrEnQ102,
  output logic      linkQ102,    // JAL or JALR
  output word_t     pcPlus4Q102
);
  regAddr_t  rs1Q102;
  regAddr_t  rs2Q102;
  aluOp_t    aluOpQ102;
  branchOp_t branchOpQ102;
  word_t     immQ102;
  word_t     pcQ102;
  word_t     data1Q102;
  word_t     data2Q102;
  logic      selAluPcQ102;
  logic      selAluImmQ102;
  logic      luiQ102;
  logic      branchQ102;
  word_t     src1;       // Forwarded operands
  word_t     src2;
  word_t     opA;
  word_t     opB;
  logic      condMet;

  ////////////////////////////////////////
  // Q101 to Q102
  ////////////////////////////////////////
  always_ff @(posedge Clock) begin
    if (rst || redirect) begin  // Wrong-path slot turns into a bubble
      branchQ102  <= 1'b0;
      linkQ102    <= 1'b0;
      loadQ102    <= 1'b0;
      storeQ102   <= 1'b0;
      regWrEnQ102 <= 1'b0;
    end else begin
      branchQ102  <= isBranch;
      linkQ102    <= isJump;
      loadQ102    <= isLoad;
      storeQ102   <= isStore;
      regWrEnQ102 <= regWrEn;
    end
  end

  always_ff @(posedge Clock) begin
    rs1Q102       <= rs1;
    rs2Q102       <= rs2;
    rdQ102        <= rd;
    aluOpQ102     <= aluOp;
    branchOpQ102  <= branchOp;
    immQ102       <= imm;
    pcQ102        <= pcQ101;
    pcPlus4Q102   <= pcPlus4Q101;
    data1Q102     <= rdData1;
    data2Q102     <= rdData2;
    selAluPcQ102  <= selAluPc;
    selAluImmQ102 <= selAluImm;
    luiQ102       <= isLui;
  end

  // Youngest producer first
  function automatic word_t fwdOperand(regAddr_t src, word_t regVal);
    if (fwdWrEn && fwdAddr == src) return aluOutQ103;
    if (wbWrEn && wbAddr == src) return wbData;
    return regVal;
  endfunction

  always_comb begin
    src1 = fwdOperand(rs1Q102, data1Q102);
    src2 = fwdOperand(rs2Q102, data2Q102);
  end

  ////////////////////////////////////////
  // ALU and branch compare
  ////////////////////////////////////////
  assign opA       = selAluPcQ102 ? pcQ102 : src1;
  assign opB       = selAluImmQ102 ? immQ102 : src2;
  assign storeData = src2;

  always_comb begin
    case (aluOpQ102)
      SUB:     aluOut = opA - opB;
      SLL:     aluOut = opA << opB[4:0];  // Shamt in low five bits
      SLT:     aluOut = word_t'($signed(opA) < $signed(opB));
      SLTU:    aluOut = word_t'(opA < opB);
      XOR:     aluOut = opA ^ opB;
      SRL:     aluOut = opA >> opB[4:0];
      SRA:     aluOut = $signed(opA) >>> opB[4:0];
      OR:      aluOut = opA | opB;
      AND:     aluOut = opA & opB;
      default: aluOut = opA + opB;  // Also addresses and targets
    endcase
    if (luiQ102) aluOut = opB;  // Immediate passes straight through
  end

  always_comb begin
    case (branchOpQ102)
      BEQ:     condMet = (src1 == src2);
      BNE:     condMet = (src1 != src2);
      BLT:     condMet = ($signed(src1) < $signed(src2));
      BGE:     condMet = ($signed(src1) >= $signed(src2));
      BLTU:    condMet = (src1 < src2);
      BGEU:    condMet = (src1 >= src2);
      default: condMet = 1'b0;
    endcase
  end

  assign redirect   = linkQ102 || (branchQ102 && condMet);
  assign redirectPc = {aluOut[wordW-1:1], 1'b0};  // JALR drops bit 0

endmodule

// ==== decode/regFile.sv ====
module regFile import rvCorePkg::*; (
  input  logic     Clock,
  input  regAddr_t rs1,
  input  regAddr_t rs2,
  output word_t    rdData1,
  output word_t    rdData2,
  input  logic     wrEn,    // Q104 write port
  input  regAddr_t wrAddr,
  input  word_t    wrData
);
  word_t regs [1:31];  // x0 is hardwired

  // Zero, then same-cycle write, then array
  function automatic word_t readPort(regAddr_t addr);
    if (addr == '0) return '0;
    if (wrEn && addr == wrAddr) return wrData;  // Write-through
    return regs[addr];
  endfunction

  always_comb begin
    rdData1 = readPort(rs1);
    rdData2 = readPort(rs2);
  end

  always_ff @(posedge Clock) begin
    if (wrEn && wrAddr != '0) regs[wrAddr] <= wrData;
  end

endmodule

// ==== decode/instrDecoder.sv ====
module instrDecoder import rvCorePkg::*, rvIsaPkg::*; (
  input  word_t     instrQ101,
  output regAddr_t  rs1,
  output regAddr_t  rs2,
  output regAddr_t  rd,
  output aluOp_t    aluOp,
  output branchOp_t branchOp,
  output word_t     imm,
  output logic      selAluPc,   // ALU A takes PC
  output logic      selAluImm,  // ALU B takes immediate
  output logic      isLui,
  output logic      isBranch,
  output logic      isJump,
  output logic      isLoad,
  output logic      isStore,
  output logic      regWrEn
);
  opcode_t    opcode;
  logic [2:0] funct3;
  logic       altFunct;  // instr[30], SUB and SRA
  immType_t   immType;
  logic       writesRd;

  assign opcode   = opcode_t'(instrQ101[6:0]);
  assign funct3   = instrQ101[14:12];
  assign altFunct = instrQ101[30];
  assign rs1      = instrQ101[19:15];
  assign rs2      = instrQ101[24:20];
  assign rd       = instrQ101[11:7];
  assign branchOp = branchOp_t'(funct3);

  ////////////////////////////////////////
  // Control bits
  ////////////////////////////////////////
  assign selAluPc  = opcode inside {JAL, BRANCH, AUIPC};  // PC-relative targets
  assign selAluImm = (opcode != R_OP);
  assign isLui     = (opcode == LUI);
  assign isBranch  = (opcode == BRANCH);
  assign isJump    = opcode inside {JAL, JALR};
  assign isLoad    = (opcode == LOAD);
  assign isStore   = (opcode == STORE);
  // FENCE and unknown opcodes fall out here
  assign writesRd  = opcode inside {LUI, AUIPC, JAL, JALR, LOAD, I_OP, R_OP};
  assign regWrEn   = writesRd && (rd != '0);  // x0 never tracked as a write

  // ALU operation, add for address and target math
  always_comb begin
    aluOp = ADD;
    if (opcode inside {R_OP, I_OP}) begin
      case (funct3)
        3'b000:  aluOp = (opcode == R_OP && altFunct) ? SUB : ADD;  // No SUBI
        3'b001:  aluOp = SLL;
        3'b010:  aluOp = SLT;
        3'b011:  aluOp = SLTU;
        3'b100:  aluOp = XOR;
        3'b101:  aluOp = altFunct ? SRA : SRL;
        3'b110:  aluOp = OR;
        default: aluOp = AND;
      endcase
    end
  end

  ////////////////////////////////////////
  // Immediate
  ////////////////////////////////////////
  always_comb begin
    case (opcode)
      STORE:      immType = S_TYPE;
      BRANCH:     immType = B_TYPE;
      LUI, AUIPC: immType = U_TYPE;
      JAL:        immType = J_TYPE;
      default:    immType = I_TYPE;  // JALR, I_OP, LOAD
    endcase
  end

  always_comb begin
    case (immType)
      S_TYPE:  imm = {{20{instrQ101[31]}}, instrQ101[31:25], instrQ101[11:7]};
      B_TYPE:  imm = {{20{instrQ101[31]}}, instrQ101[7], instrQ101[30:25],
                      instrQ101[11:8], 1'b0};
      U_TYPE:  imm = {instrQ101[31:12], 12'b0};  // Upper 20 bits
      J_TYPE:  imm = {{12{instrQ101[31]}}, instrQ101[19:12], instrQ101[20],
                      instrQ101[30:21], 1'b0};
      default: imm = {{20{instrQ101[31]}}, instrQ101[31:20]};
    endcase
  end

endmodule

// ==== decode/hazardUnit.sv ====
module hazardUnit import rvCorePkg::*, rvIsaPkg::*; (
  input  logic     Clock,
  input  logic     rst,
  input  word_t    imemData,   // Raw word from instruction memory
  input  logic     flush,      // Taken branch or jump in Q102
  input  regAddr_t rdQ102,
  input  logic     loadQ102,
  output logic     pcEn,
  output word_t    instrQ101
);
  word_t prevInstr;  // Raw word of the last cycle
  logic  stall;
  logic  replay;     // Cycle after a stall
  logic  flushDly;   // Second squashed slot
  logic  rs1Hit;
  logic  rs2Hit;

  assign rs1Hit = (imemData[19:15] == rdQ102);
  assign rs2Hit = (imemData[24:20] == rdQ102);
  assign stall  = loadQ102 && (rs1Hit || rs2Hit);  // Load data not ready until Q104
  assign pcEn   = !stall;

  always_comb begin
    if (flush || flushDly || stall) instrQ101 = nopInstr;
    else if (replay) instrQ101 = prevInstr;  // Memory has moved past it
    else instrQ101 = imemData;
  end

  always_ff @(posedge Clock) begin
    if (rst) begin
      replay   <= 1'b0;
      flushDly <= 1'b1;  // Word fetched during reset is dropped
    end else begin
      replay   <= stall;
      flushDly <= flush;
    end
  end

  always_ff @(posedge Clock) prevInstr <= imemData;

endmodule

// ==== src/fetchUnit.sv ====
module fetchUnit import rvCorePkg::*; (
  input  logic  Clock,
  input  logic  rst,
  input  logic  pcEn,         // Low during load-use stall
  input  logic  redirect,
  input  word_t redirectPc,
  output word_t imemAddr,
  output word_t pcQ101,
  output word_t pcPlus4Q101
);
  word_t pc;       // Q100 PC
  word_t pcPlus4;

  assign imemAddr = pc;
  assign pcPlus4  = pc + wordW'(4);

  // Redirect wins over a hold
  always_ff @(posedge Clock) begin
    if (rst) pc <= resetPc;
    else if (redirect) pc <= redirectPc;  // Branch or jump target from Q102
    else if (pcEn) pc <= pcPlus4;
  end

  // Q100 to Q101, held with the PC during a stall
  always_ff @(posedge Clock) begin
    if (pcEn) begin
      pcQ101      <= pc;
      pcPlus4Q101 <= pcPlus4;
    end
  end

endmodule

// ==== common/rvIsaPkg.sv ====
package rvIsaPkg;

  // Major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    I_OP   = 7'b0010011,  // Register-immediate ALU
    R_OP   = 7'b0110011   // Register-register ALU
  } opcode_t;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
  } aluOp_t;

  // Values are the funct3 field itself
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branchOp_t;

  typedef enum logic [2:0] {I_TYPE, S_TYPE, B_TYPE, U_TYPE, J_TYPE} immType_t;

  localparam logic [31:0] nopInstr = 32'h0000_0013;  // ADDI x0,x0,0

endpackage

// ==== common/rvCorePkg.sv ====
package rvCorePkg;

  localparam int wordW = 32;  // Data and address width

  // One data or address word
  typedef logic [wordW-1:0] word_t;

  typedef logic [4:0] regAddr_t;  // x0 to x31

  // Boot address
  localparam word_t resetPc = '0;

endpackage
